// ==== hdl/rv_core_settings.svh ====
// build-time constants of rv_core, included by the stages that need them
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// data ram size in 32-bit words, power of two
`define RV_DMEM_WORDS 256

`endif

// ==== hdl/rv_core_pkg.sv ====
// shared types for the rv_core pipeline, imported by the core modules and the testbench
`default_nettype none

package rv_core_pkg;

	localparam logic [6:0] OPC_OP     = 7'b0110011; // register alu
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // immediate alu
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111; // standard encoding, not shared with jal
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	typedef struct packed {logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} r_fmt_t;
	typedef struct packed {logic [11:0] imm; logic [4:0] rs1;
		logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} i_fmt_t;
	typedef struct packed {logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;} s_fmt_t;
	typedef struct packed {logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
		logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;} b_fmt_t;
	typedef struct packed {logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;} u_fmt_t;
	typedef struct packed {logic imm20; logic [9:0] imm10_1; logic imm11;
		logic [7:0] imm19_12; logic [4:0] rd; logic [6:0] opcode;} j_fmt_t;

	typedef union packed {r_fmt_t r; i_fmt_t i; s_fmt_t s; b_fmt_t b; u_fmt_t u; j_fmt_t j;} instr_u;

	typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;
	typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_FOUR} op2_sel_e;
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

	typedef struct packed {
		op1_sel_e op1_sel;
		op2_sel_e op2_sel;
		alu_op_e  alu_op;
		logic     mem_wr;
		logic     mem_rd;
		logic     reg_wr;
		wb_sel_e  wb_sel;
		logic     is_br;
		logic     br_ne;  // bne when set, beq otherwise
		logic     is_jal;
		logic     is_jalr;
	} ctrl_t;

	// no-op word, everything off
	localparam ctrl_t CTRL_NOP = '{op1_sel: OP1_RS1, op2_sel: OP2_RS2, alu_op: ALU_ADD,
		mem_wr: 1'b0, mem_rd: 1'b0, reg_wr: 1'b0, wb_sel: WB_ALU, is_br: 1'b0,
		br_ne: 1'b0, is_jal: 1'b0, is_jalr: 1'b0};

	typedef struct packed {logic valid; logic [31:0] pc; ctrl_t ctrl; logic [4:0] rs1;
		logic [4:0] rs2; logic [4:0] rd; logic [31:0] rs1_val; logic [31:0] rs2_val;
		logic [31:0] imm;} id_ex_t;

	typedef struct packed {logic valid; logic [31:0] pc; logic [4:0] rd; ctrl_t ctrl;
		logic [31:0] result; logic [31:0] store_data;} ex_wb_t;

	typedef struct packed {logic [31:0] pc; logic [4:0] rd; logic reg_wr;
		logic [31:0] data;} commit_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// fetch stage of rv_core: program counter and the fetch/decode pipeline register
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_settings.svh"

module fetch_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                redirect,     // taken branch or jump in execute
	input  logic [31:0]         redirect_pc,
	output logic [31:0]         fetch_addr,   // to instruction rom
	input  rv_core_pkg::instr_u fetch_instr,  // same-cycle rom data
	output logic                fd_valid,
	output logic [31:0]         fd_pc,
	output rv_core_pkg::instr_u fd_instr
);

	logic [31:0] pc;

	assign fetch_addr = pc;

	// pc and fetch/decode valid
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= `RV_RESET_PC;
			fd_valid <= 1'b0;
		end
		else if (redirect)
		begin
			pc <= redirect_pc;  // restart at target
			fd_valid <= 1'b0;   // kill word fetched this cycle
		end
		else
		begin
			pc <= pc + 32'd4;   // sequential
			fd_valid <= 1'b1;
		end
	end

	// fetch/decode payload
	always_ff @(posedge clk)
	begin
		fd_pc <= pc;
		fd_instr <= fetch_instr;
	end

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
// decode control block of rv_core: turns one instruction word into control bits and immediate
`timescale 1ns/10ps
`default_nettype none

module decoder (
	input  rv_core_pkg::instr_u instr,
	output rv_core_pkg::ctrl_t  ctrl,
	output logic [31:0]         imm
);

	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_e    alu_f3;    // alu op implied by funct3
	logic       f3_known;  // funct3 is one of the kept alu ops
	logic       r_ok;      // funct7 legal for register form

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;

	// funct3 map shared by register and immediate forms
	always_comb
	begin
		f3_known = 1'b1;
		case (funct3)
			3'b000: alu_f3 = ALU_ADD;
			3'b010: alu_f3 = ALU_SLT;
			3'b100: alu_f3 = ALU_XOR;
			3'b110: alu_f3 = ALU_OR;
			3'b111: alu_f3 = ALU_AND;
			default:
			begin
				alu_f3 = ALU_ADD;  // shifts, sltu
				f3_known = 1'b0;
			end
		endcase
	end

	// only sub may set funct7 bit 5; mul and friends drop out
	assign r_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);

	always_comb
	begin
		ctrl = CTRL_NOP;  // unknown opcode, commits nothing
		imm = 32'd0;
		case (opcode)
			OPC_OP:
			begin
				ctrl.alu_op = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : alu_f3;
				ctrl.reg_wr = f3_known && r_ok;
			end
			OPC_OP_IMM:
			begin
				ctrl.op2_sel = OP2_IMM;
				ctrl.alu_op = alu_f3;
				ctrl.reg_wr = f3_known;
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			OPC_LOAD:  // lw only
			begin
				ctrl.op2_sel = OP2_IMM;      // address = rs1 + imm
				ctrl.mem_rd = (funct3 == 3'b010);
				ctrl.reg_wr = (funct3 == 3'b010);
				ctrl.wb_sel = WB_MEM;
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			OPC_STORE:  // sw only
			begin
				ctrl.op2_sel = OP2_IMM;
				ctrl.mem_wr = (funct3 == 3'b010);
				imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			end
			OPC_BRANCH:  // beq, bne
			begin
				ctrl.is_br = (funct3[2:1] == 2'b00);
				ctrl.br_ne = funct3[0];
				imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
					instr.b.imm10_5, instr.b.imm4_1, 1'b0};
			end
			OPC_JAL:
			begin
				ctrl.op1_sel = OP1_PC;
				ctrl.op2_sel = OP2_FOUR;     // link = pc + 4 through alu
				ctrl.reg_wr = 1'b1;
				ctrl.is_jal = 1'b1;
				imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
					instr.j.imm11, instr.j.imm10_1, 1'b0};
			end
			OPC_JALR:
			begin
				ctrl.op2_sel = OP2_IMM;      // alu forms the target
				ctrl.reg_wr = (funct3 == 3'b000);
				ctrl.is_jalr = (funct3 == 3'b000);
				ctrl.wb_sel = WB_PC4;
				imm = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			OPC_LUI:
			begin
				ctrl.op2_sel = OP2_IMM;      // rs1 forced to x0 upstream
				ctrl.reg_wr = 1'b1;
				imm = {instr.u.imm, 12'd0};
			end
			OPC_AUIPC:
			begin
				ctrl.op1_sel = OP1_PC;
				ctrl.op2_sel = OP2_IMM;
				ctrl.reg_wr = 1'b1;
				imm = {instr.u.imm, 12'd0};
			end
			default:
			begin
				ctrl = CTRL_NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// integer register file of rv_core, read in decode and written from writeback
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rs1_val,
	output logic [31:0] rs2_val,
	input  logic        wb_we,
	input  logic [4:0]  wb_rd,
	input  logic [31:0] wb_data
);

	logic [31:0] regs [0:31];  // entry 0 never written

	// one read port, x0 zero, same-cycle write passes through
	function automatic logic [31:0] rd_port(input logic [4:0] idx, input logic [31:0] stored,
		input logic we, input logic [4:0] wr_idx, input logic [31:0] wr_data);
		if (idx == 5'd0)
			return 32'd0;
		if (we && wr_idx == idx)
			return wr_data;  // covers the instruction two ahead
		return stored;
	endfunction

	assign rs1_val = rd_port(rs1, regs[rs1], wb_we, wb_rd, wb_data);
	assign rs2_val = rd_port(rs2, regs[rs2], wb_we, wb_rd, wb_data);

	always_ff @(posedge clk)
	begin
		if (wb_we && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// execute stage of rv_core: forwarding, alu, branch resolve and the execute/writeback register
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  rv_core_pkg::id_ex_t de,
	input  logic                wb_fwd_we,    // already excludes x0
	input  logic [4:0]          wb_fwd_rd,
	input  logic [31:0]         wb_fwd_data,
	output logic                redirect,
	output logic [31:0]         redirect_pc,
	output rv_core_pkg::ex_wb_t ew_next,      // value captured at the next edge
	output rv_core_pkg::ex_wb_t ew
);

	import rv_core_pkg::*;

	logic [31:0] rs1_fwd;
	logic [31:0] rs2_fwd;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_res;
	logic [31:0] br_target;
	logic        taken;

	// writeback result overrides the stale register read
	function automatic logic [31:0] fwd(input logic [4:0] idx, input logic [31:0] rf_val,
		input logic we, input logic [4:0] wr_idx, input logic [31:0] wr_data);
		if (we && wr_idx == idx)
			return wr_data;
		return rf_val;
	endfunction

	assign rs1_fwd = fwd(de.rs1, de.rs1_val, wb_fwd_we, wb_fwd_rd, wb_fwd_data);
	assign rs2_fwd = fwd(de.rs2, de.rs2_val, wb_fwd_we, wb_fwd_rd, wb_fwd_data);

	assign op1 = (de.ctrl.op1_sel == OP1_PC) ? de.pc : rs1_fwd;

	always_comb
	begin
		case (de.ctrl.op2_sel)
			OP2_IMM:  op2 = de.imm;
			OP2_FOUR: op2 = 32'd4;   // jal link
			default:  op2 = rs2_fwd;
		endcase
	end

	always_comb
	begin
		case (de.ctrl.alu_op)
			ALU_SUB: alu_res = op1 - op2;
			ALU_AND: alu_res = op1 & op2;
			ALU_OR:  alu_res = op1 | op2;
			ALU_XOR: alu_res = op1 ^ op2;
			ALU_SLT: alu_res = {31'd0, $signed(op1) < $signed(op2)};
			default: alu_res = op1 + op2;  // add, addresses, auipc
		endcase
	end

	// beq when equal, bne when not
	assign taken = de.ctrl.is_br && ((rs1_fwd == rs2_fwd) != de.ctrl.br_ne);
	assign br_target = de.pc + de.imm;  // branches and jal

	assign redirect = de.valid && (taken || de.ctrl.is_jal || de.ctrl.is_jalr);
	assign redirect_pc = de.ctrl.is_jalr ? {alu_res[31:1], 1'b0} : br_target;

	always_comb
	begin
		ew_next.valid = de.valid;
		ew_next.pc = de.pc;
		ew_next.rd = de.rd;
		ew_next.ctrl = de.ctrl;
		ew_next.result = alu_res;     // also the memory address
		ew_next.store_data = rs2_fwd;
	end

	always_ff @(posedge clk)
	begin
		ew <= ew_next;
		if (!rst_n)
			ew.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
// writeback stage of rv_core: data ram, result select, register write and commit record
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_settings.svh"

module writeback_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_core_pkg::ex_wb_t  ew_next,  // entering writeback at this edge
	input  rv_core_pkg::ex_wb_t  ew,       // in writeback now
	output logic                 wb_we,
	output logic [4:0]           wb_rd,
	output logic [31:0]          wb_data,
	output logic                 commit_valid,
	output rv_core_pkg::commit_t commit
);

	import rv_core_pkg::*;

	localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

	logic [31:0]        dmem [0:`RV_DMEM_WORDS-1];
	logic [31:0]        load_q;   // read data, valid in writeback cycle
	logic [DMEM_AW-1:0] mem_idx;

	assign mem_idx = ew_next.result[DMEM_AW+1:2];  // word index

	// ram access on the execute-to-writeback edge
	always_ff @(posedge clk)
	begin
		if (rst_n && ew_next.valid && ew_next.ctrl.mem_wr)
			dmem[mem_idx] <= ew_next.store_data;
		if (ew_next.ctrl.mem_rd)
			load_q <= dmem[mem_idx];
	end

	always_comb
	begin
		case (ew.ctrl.wb_sel)
			WB_MEM:  wb_data = load_q;
			WB_PC4:  wb_data = ew.pc + 32'd4;  // jalr link
			default: wb_data = ew.result;
		endcase
	end

	assign wb_we = ew.valid && ew.ctrl.reg_wr && (ew.rd != 5'd0);  // x0 writes dropped
	assign wb_rd = ew.rd;

	assign commit_valid = ew.valid;
	assign commit.pc = ew.pc;
	assign commit.rd = ew.rd;
	assign commit.reg_wr = wb_we;
	assign commit.data = wb_we ? wb_data : 32'd0;  // nothing written, nothing reported

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
// top level of rv_core: links fetch, decode, execute and writeback and holds the decode/execute register
`timescale 1ns/10ps
`default_nettype none

module rv_core (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [31:0]          fetch_addr,
	input  rv_core_pkg::instr_u  fetch_instr,
	output logic                 commit_valid,
	output rv_core_pkg::commit_t commit
);

	import rv_core_pkg::*;

	logic        redirect;
	logic [31:0] redirect_pc;
	logic        fd_valid;
	logic [31:0] fd_pc;
	instr_u      fd_instr;
	ctrl_t       dec_ctrl;
	logic [31:0] dec_imm;
	logic [4:0]  rs1_idx;
	logic [4:0]  rs2_idx;
	logic [4:0]  rd_idx;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic        dec_live;  // decoded word enters execute
	id_ex_t      de;
	ex_wb_t      ew_next;
	ex_wb_t      ew;
	logic        wb_we;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	fetch_stage fetch0 (.clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
		.fetch_addr(fetch_addr), .fetch_instr(fetch_instr), .fd_valid(fd_valid), .fd_pc(fd_pc),
		.fd_instr(fd_instr));

	decoder dec0 (.instr(fd_instr), .ctrl(dec_ctrl), .imm(dec_imm));

	assign rs1_idx = (fd_instr.u.opcode == OPC_LUI) ? 5'd0 : fd_instr.r.rs1;  // lui adds to zero
	assign rs2_idx = fd_instr.r.rs2;
	assign rd_idx = dec_ctrl.reg_wr ? fd_instr.r.rd : 5'd0;  // stores and branches carry no rd

	reg_file rf0 (.clk(clk), .rs1(rs1_idx), .rs2(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data));

	// no-op opcodes never reach execute, so they never commit
	assign dec_live = fd_valid && !redirect &&
		(dec_ctrl.reg_wr || dec_ctrl.mem_wr || dec_ctrl.is_br);

	// decode/execute register
	always_ff @(posedge clk)
	begin
		de.valid <= dec_live;
		de.pc <= fd_pc;
		de.ctrl <= dec_ctrl;
		de.rs1 <= rs1_idx;
		de.rs2 <= rs2_idx;
		de.rd <= rd_idx;
		de.rs1_val <= rs1_val;
		de.rs2_val <= rs2_val;
		de.imm <= dec_imm;
		if (!rst_n)
			de.valid <= 1'b0;
	end

	execute_stage ex0 (.clk(clk), .rst_n(rst_n), .de(de), .wb_fwd_we(wb_we), .wb_fwd_rd(wb_rd),
		.wb_fwd_data(wb_data), .redirect(redirect), .redirect_pc(redirect_pc),
		.ew_next(ew_next), .ew(ew));

	writeback_stage wb0 (.clk(clk), .rst_n(rst_n), .ew_next(ew_next), .ew(ew), .wb_we(wb_we),
		.wb_rd(wb_rd), .wb_data(wb_data), .commit_valid(commit_valid), .commit(commit));

endmodule

`default_nettype wire

// ==== tb/rv_core_props.sv ====
// concurrent checks on rv_core ports and redirect, bound into every rv_core instance
`timescale 1ns/10ps
`default_nettype none

module rv_core_props (
	input logic                 clk,
	input logic                 rst_n,
	input logic [31:0]          fetch_addr,
	input logic                 commit_valid,
	input rv_core_pkg::commit_t commit,
	input logic                 redirect,      // internal to the core
	input logic [31:0]          redirect_pc
);

	int fail_count = 0;  // failed assertion total

	// quiet in reset and the first cycle after
	no_commit_in_reset: assert property (@(posedge clk) $past(!rst_n) |-> !commit_valid)
	else
	begin
		fail_count++;
		$error("commit_valid high during reset or in the cycle after it");
	end

	fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_addr[1:0] == 2'b00)
	else
	begin
		fail_count++;
		$error("fetch_addr %h not word aligned", fetch_addr);
	end

	x0_never_written: assert property (@(posedge clk) disable iff (!rst_n)
		(commit_valid && commit.rd == 5'd0) |-> !commit.reg_wr)
	else
	begin
		fail_count++;
		$error("commit to x0 reports a register write");
	end

	// pc follows the redirect one cycle later
	redirect_taken: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |=> fetch_addr == $past(redirect_pc))
	else
	begin
		fail_count++;
		$error("fetch_addr did not follow the redirect");
	end

endmodule

bind rv_core rv_core_props props0 (.clk(clk), .rst_n(rst_n), .fetch_addr(fetch_addr),
	.commit_valid(commit_valid), .commit(commit), .redirect(redirect),
	.redirect_pc(redirect_pc));

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
// self-checking testbench for rv_core: random program in a rom, reference model, commit compare
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_settings.svh"

module rv_core_tb;

	import rv_core_pkg::*;

	localparam int PROG_LEN = 200;                      // generated instructions
	localparam int ROM_WORDS = 256;                     // tail stays no-op
	localparam int TIMEOUT_CYCLES = PROG_LEN * 3 + 50;
	localparam logic [31:0] NOP_WORD = 32'h0000_000f;   // fence, not in the kept set
	localparam logic [2:0] IMM_F3 [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

	logic        clk;
	logic        rst_n;
	logic [31:0] fetch_addr;
	instr_u      fetch_instr;
	logic        commit_valid;
	commit_t     commit;

	instr_u      rom [0:ROM_WORDS-1];
	logic        landed [0:ROM_WORDS];          // some branch or jump lands here
	logic [31:0] m_regs [0:31];                 // model register file
	logic [31:0] m_mem [0:`RV_DMEM_WORDS-1];    // model data ram
	commit_t     exp_q [$];                     // expected commits, program order
	integer      seed;
	int          mismatches;
	int          other_errors;
	int          commits_seen;
	int          cycles;

	rv_core dut0 (.clk(clk), .rst_n(rst_n), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr),
		.commit_valid(commit_valid), .commit(commit));

	always #10 clk = ~clk;  // 20 ns period

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// out of range reads as no-op
	function automatic instr_u rom_read(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - `RV_RESET_PC) >> 2;
		if (idx < ROM_WORDS)
			return rom[idx];
		return NOP_WORD;
	endfunction

	function automatic instr_u enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		instr_u w;
		w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
		return w;
	endfunction

	function automatic instr_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		instr_u w;
		w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
		return w;
	endfunction

	function automatic instr_u enc_s(input logic [11:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1);
		instr_u w;
		w.s = '{imm_hi: off[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010, imm_lo: off[4:0],
			opcode: OPC_STORE};
		return w;
	endfunction

	function automatic instr_u enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		instr_u w;
		w.b = '{imm12: off[12], imm10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
			imm4_1: off[4:1], imm11: off[11], opcode: OPC_BRANCH};
		return w;
	endfunction

	function automatic instr_u enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		instr_u w;
		w.u = '{imm: imm, rd: rd, opcode: opc};
		return w;
	endfunction

	function automatic instr_u enc_j(input logic [20:0] off, input logic [4:0] rd);
		instr_u w;
		w.j = '{imm20: off[20], imm10_1: off[10:1], imm11: off[11], imm19_12: off[19:12],
			rd: rd, opcode: OPC_JAL};
		return w;
	endfunction

	// forward target from slot i, at most end of program
	function automatic int fwd_target(input int i, input int min_dist);
		int t;
		t = i + min_dist + pick(6);
		return (t > PROG_LEN) ? PROG_LEN : t;
	endfunction

	// prologue sets x1..x7 and the 16 data words, then a random body on x0..x7
	task automatic gen_program();
		int         i;
		int         kind;
		int         t;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		for (i = 0; i <= ROM_WORDS; i++)
		begin
			if (i < ROM_WORDS)
				rom[i] = NOP_WORD;
			landed[i] = 1'b0;
		end
		for (i = 1; i < 8; i++)
			rom[i-1] = enc_i(pick(4096), 5'd0, 3'b000, i, OPC_OP_IMM);
		for (i = 0; i < 16; i++)
			rom[7+i] = enc_s(i * 4, pick(8), 5'd0);
		i = 23;
		while (i < PROG_LEN)
		begin
			kind = pick(16);
			rd = pick(8);
			ra = pick(8);
			rb = pick(8);
			if (kind == 14 && (i + 3 > PROG_LEN || landed[i+1] || landed[i+2]))
				kind = 0;  // jalr setup must not be skipped into
			if (kind == 11 && i + 2 > PROG_LEN)
				kind = 0;
			case (kind)
				0, 1, 2, 3, 4:
				begin
					case (pick(6))
						0: rom[i] = enc_r(7'h00, rb, ra, 3'b000, rd);  // add
						1: rom[i] = enc_r(7'h20, rb, ra, 3'b000, rd);  // sub
						2: rom[i] = enc_r(7'h00, rb, ra, 3'b111, rd);  // and
						3: rom[i] = enc_r(7'h00, rb, ra, 3'b110, rd);  // or
						4: rom[i] = enc_r(7'h00, rb, ra, 3'b100, rd);  // xor
						default: rom[i] = enc_r(7'h00, rb, ra, 3'b010, rd);  // slt
					endcase
					i++;
				end
				5, 6, 7, 8:
				begin
					rom[i] = enc_i(pick(4096), ra, IMM_F3[pick(5)], rd, OPC_OP_IMM);
					i++;
				end
				9:
				begin
					rom[i] = enc_u(pick(1 << 20), rd, pick(2) ? OPC_LUI : OPC_AUIPC);
					i++;
				end
				10:
				begin
					rom[i] = enc_i(pick(16) * 4, 5'd0, 3'b010, rd, OPC_LOAD);
					i++;
				end
				11:
				begin
					t = pick(16) * 4;  // store then load of the same word
					rom[i] = enc_s(t, rb, 5'd0);
					rom[i+1] = enc_i(t, 5'd0, 3'b010, rd, OPC_LOAD);
					i += 2;
				end
				12:
				begin
					t = fwd_target(i, 2);
					landed[t] = 1'b1;
					rom[i] = enc_b((t - i) * 4, rb, ra, pick(2) ? 3'b001 : 3'b000);
					i++;
				end
				13:
				begin
					t = fwd_target(i, 2);
					landed[t] = 1'b1;
					rom[i] = enc_j((t - i) * 4, rd);
					i++;
				end
				14:
				begin
					t = fwd_target(i, 3);
					landed[t] = 1'b1;
					rom[i] = enc_u(20'd0, 5'd31, OPC_AUIPC);             // x31 = pc
					rom[i+1] = enc_i((t - i) * 4, 5'd31, 3'b000, 5'd31, OPC_OP_IMM);
					rom[i+2] = enc_i(12'd0, 5'd31, 3'b000, rd, OPC_JALR);
					i += 3;
				end
				default:
				begin
					rom[i] = pick(2) ? NOP_WORD : 32'd0;
					i++;
				end
			endcase
		end
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// sequential ISA model, one instruction per step
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic        writes;
		logic        live;
		instr_u      w;
		commit_t     c;
		int          k;
		for (k = 0; k < 32; k++)
			m_regs[k] = 32'd0;
		pc = `RV_RESET_PC;
		while (((pc - `RV_RESET_PC) >> 2) < PROG_LEN)
		begin
			w = rom[(pc - `RV_RESET_PC) >> 2];
			a = m_regs[w.r.rs1];
			b = m_regs[w.r.rs2];
			imm_i = {{20{w.i.imm[11]}}, w.i.imm};
			next_pc = pc + 32'd4;
			val = 32'd0;
			writes = 1'b1;
			live = 1'b1;
			case (w.r.opcode)
				OPC_OP: val = alu_ref(w.r.funct3, w.r.funct7[5], a, b);
				OPC_OP_IMM: val = alu_ref(w.i.funct3, 1'b0, a, imm_i);
				OPC_LOAD:
				begin
					addr = a + imm_i;
					val = m_mem[addr[31:2] % `RV_DMEM_WORDS];
				end
				OPC_STORE:
				begin
					addr = a + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
					m_mem[addr[31:2] % `RV_DMEM_WORDS] = b;
					writes = 1'b0;
				end
				OPC_BRANCH:
				begin
					writes = 1'b0;
					if ((a == b) != w.b.funct3[0])  // bne has funct3 bit 0 set
						next_pc = pc + {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5,
							w.b.imm4_1, 1'b0};
				end
				OPC_JAL:
				begin
					val = pc + 32'd4;
					next_pc = pc + {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
						w.j.imm10_1, 1'b0};
				end
				OPC_JALR:
				begin
					val = pc + 32'd4;
					next_pc = (a + imm_i) & ~32'd1;
				end
				OPC_LUI: val = {w.u.imm, 12'd0};
				OPC_AUIPC: val = pc + {w.u.imm, 12'd0};
				default: live = 1'b0;  // no-op, no commit
			endcase
			if (live)
			begin
				c.pc = pc;
				c.rd = writes ? w.r.rd : 5'd0;
				c.reg_wr = writes && (w.r.rd != 5'd0);
				c.data = c.reg_wr ? val : 32'd0;
				exp_q.push_back(c);
				if (c.reg_wr)
					m_regs[w.r.rd] = val;
			end
			pc = next_pc;
		end
	endtask

	task automatic check_commit(input commit_t got, input commit_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch commit: got pc=%h rd=%h reg_wr=%h data=%h", got.pc, got.rd,
				got.reg_wr, got.data);
			$display("  expected pc=%h rd=%h reg_wr=%h data=%h", exp.pc, exp.rd, exp.reg_wr,
				exp.data);
		end
	endtask

	task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch fetch_addr: got %h expected %h", got, exp);
		end
	endtask

	// instruction rom answers on the falling edge
	always @(negedge clk)
	begin
		fetch_instr <= rom_read(fetch_addr);
	end

	initial
	begin
		seed = 9;
		clk = 1'b0;
		rst_n = 1'b0;
		fetch_instr = NOP_WORD;
		mismatches = 0;
		other_errors = 0;
		commits_seen = 0;
		cycles = 0;
		gen_program();
		run_model();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_addr(fetch_addr, `RV_RESET_PC);  // first fetch after reset
		while (exp_q.size() > 0 && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			if (commit_valid)
			begin
				commits_seen++;
				check_commit(commit, exp_q.pop_front());
			end
		end
		if (exp_q.size() > 0)
		begin
			other_errors++;
			$display("timeout after %0d cycles, %0d commits never arrived", cycles, exp_q.size());
		end
		else
		begin
			repeat (4)  // pipeline drains, nothing more may commit
			begin
				@(negedge clk);
				if (commit_valid)
				begin
					other_errors++;
					$display("extra commit at pc %h after the last expected one", commit.pc);
				end
			end
		end
		$display("checked %0d commits: %0d mismatches, %0d other errors, %0d assertion failures",
			commits_seen, mismatches, other_errors, dut0.props0.fail_count);
		if (mismatches == 0 && other_errors == 0 && dut0.props0.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decoder.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/rv_core_props.sv
      - tb/rv_core_tb.sv
